/* common/sb_defs.svh */
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// widths
`define SB_PKT_W        64
`define SB_MSG_NO_W     4
`define SB_INFO_W       3
`define SB_DATA_W       16
`define SB_STATE_W      4

// packet field positions, low and high bit
`define SB_OP_LO        0
`define SB_OP_HI        4
`define SB_CODE_LO      14
`define SB_CODE_HI      21
// subcode carries the message number in its low nibble
`define SB_SUB_LO       22
`define SB_SUB_HI       29
`define SB_INFO_LO      30
`define SB_INFO_HI      32
`define SB_DATA_LO      33
`define SB_DATA_HI      48
`define SB_PAR_BIT      63

// opcodes and message codes
`define SB_OP_NODATA    5'h12
`define SB_OP_DATA      5'h1B
`define SB_CODE_RDI_REQ 8'h01
`define SB_CODE_RDI_RSP 8'h02
`define SB_CODE_MB      8'h85

// buffering and serializer pacing
`define SB_FIFO_DEPTH   4
`define SB_SER_CYCLES   64
`define SB_GAP_CYCLES   32

`endif

/* common/sb_pkg.sv */
`include "sb_defs.svh"

package sb_pkg;

    // one sideband packet, parity in the top bit
    typedef logic [`SB_PKT_W-1:0] sb_pkt_t;

    // link training state machine states
    typedef enum logic [`SB_STATE_W-1:0] {
        RESET            = 4'd0,
        FINISH_RESET     = 4'd1,
        SBINIT           = 4'd2,
        MBINIT           = 4'd3,
        MBTRAIN          = 4'd4,
        LINKINIT         = 4'd5,
        // link up, mainband owned by the adapter
        ACTIVE           = 4'd6,
        TRAINERROR_HS    = 4'd7,
        TRAINERROR       = 4'd8,
        LINKMGMT_RETRAIN = 4'd9,
        PHYRETRAIN       = 4'd10,
        // low power states
        L1               = 4'd11,
        L2               = 4'd12
    } ltsm_state_t;

endpackage

/* tx/sb_rdi_tx_encoder.sv */
`include "sb_defs.svh"

module sb_rdi_tx_encoder (
    input  logic                    i_sb_clk,
    input  logic                    i_reset,
    input  logic                    i_msg_valid,
    input  logic [`SB_MSG_NO_W-1:0] i_msg_no,
    input  logic                    i_grant,
    output logic                    o_req,
    output sb_pkg::sb_pkt_t         o_pkt,
    output logic                    o_msg_done
);

    sb_pkg::sb_pkt_t pkt_d;
    logic            accept;

    // slot is free only while no request is pending
    assign accept = i_msg_valid & ~o_req;

    // nodata request packet, message number in subcode low nibble
    always_comb begin
        pkt_d = '0;
        pkt_d[`SB_OP_HI:`SB_OP_LO] = `SB_OP_NODATA;
        pkt_d[`SB_CODE_HI:`SB_CODE_LO] = `SB_CODE_RDI_REQ;
        pkt_d[`SB_SUB_LO +: `SB_MSG_NO_W] = i_msg_no;
        // even parity over the whole packet
        pkt_d[`SB_PAR_BIT] = ^pkt_d;
    end

    // request held until the arbiter writes the packet
    always_ff @(posedge i_sb_clk) begin
        if (i_reset) begin
            o_req <= 1'b0;
        end else if (accept) begin
            o_req <= 1'b1;
        end else if (i_grant) begin
            o_req <= 1'b0;
        end
    end

    always_ff @(posedge i_sb_clk) begin
        if (accept) begin
            o_pkt <= pkt_d;
        end
    end

    // done in the cycle the fifo write happens
    assign o_msg_done = i_grant & o_req;

endmodule

/* tx/sb_mb_tx_encoder.sv */
`include "sb_defs.svh"

module sb_mb_tx_encoder (
    input  logic                    i_sb_clk,
    input  logic                    i_reset,
    input  logic                    i_msg_valid,
    input  logic [`SB_MSG_NO_W-1:0] i_msg_no,
    input  logic [`SB_INFO_W-1:0]   i_msg_info,
    input  logic [`SB_DATA_W-1:0]   i_data_bus,
    input  logic                    i_grant,
    output logic                    o_req,
    output sb_pkg::sb_pkt_t         o_pkt,
    output logic                    o_busy
);

    sb_pkg::sb_pkt_t pkt_d;
    logic            accept;

    // strobes while a packet is pending are dropped
    assign accept = i_msg_valid & ~o_req;

    // data packet for training messages
    always_comb begin
        pkt_d = '0;
        pkt_d[`SB_OP_HI:`SB_OP_LO] = `SB_OP_DATA;
        pkt_d[`SB_CODE_HI:`SB_CODE_LO] = `SB_CODE_MB;
        // upper subcode nibble stays zero
        pkt_d[`SB_SUB_LO +: `SB_MSG_NO_W] = i_msg_no;
        pkt_d[`SB_INFO_HI:`SB_INFO_LO] = i_msg_info;
        pkt_d[`SB_DATA_HI:`SB_DATA_LO] = i_data_bus;
        // parity bit is still zero here, so xor of all bits works
        pkt_d[`SB_PAR_BIT] = ^pkt_d;
    end

    // pending slot
    always_ff @(posedge i_sb_clk) begin
        if (i_reset) begin
            o_req <= 1'b0;
        end else if (accept) begin
            o_req <= 1'b1;
        end else if (i_grant) begin
            o_req <= 1'b0;
        end
    end

    always_ff @(posedge i_sb_clk) begin
        if (accept) begin
            o_pkt <= pkt_d;
        end
    end

    // busy from the cycle after the strobe
    // until the cycle after the grant
    // also stays up while the fifo is full
    assign o_busy = o_req;

endmodule

/* tx/sb_tx_arbiter.sv */
module sb_tx_arbiter (
    input  logic            i_rdi_req,
    input  sb_pkg::sb_pkt_t i_rdi_pkt,
    input  logic            i_mb_req,
    input  sb_pkg::sb_pkt_t i_mb_pkt,
    input  logic            i_fifo_full,
    output logic            o_rdi_grant,
    output logic            o_mb_grant,
    output logic            o_wr_en,
    output sb_pkg::sb_pkt_t o_wr_data
);

    logic room;

    // no grant at all while the fifo is full
    assign room = ~i_fifo_full;

    // fixed priority with rdi first
    always_comb begin
        o_rdi_grant = 1'b0;
        o_mb_grant  = 1'b0;
        if (room) begin
            if (i_rdi_req) begin
                o_rdi_grant = 1'b1;
            end else if (i_mb_req) begin
                o_mb_grant = 1'b1;
            end
        end
    end

    // one writer per cycle
    assign o_wr_en = o_rdi_grant | o_mb_grant;

    // mb data whenever rdi is not granted
    always_comb begin
        if (o_rdi_grant) begin
            o_wr_data = i_rdi_pkt;
        end else begin
            o_wr_data = i_mb_pkt;
        end
    end

endmodule

/* tx/sb_tx_fifo.sv */
`include "sb_defs.svh"

module sb_tx_fifo #(
    parameter int DEPTH = `SB_FIFO_DEPTH
) (
    input  logic            i_sb_clk,
    input  logic            i_reset,
    input  logic            i_wr_en,
    input  sb_pkg::sb_pkt_t i_wr_data,
    input  logic            i_pop,
    output sb_pkg::sb_pkt_t o_head,
    output logic            o_empty,
    output logic            o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sb_pkg::sb_pkt_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // qualify against full and empty
    assign do_wr = i_wr_en & ~o_full;
    assign do_rd = i_pop & ~o_empty;

    // packet storage
    always_ff @(posedge i_sb_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // pointers wrap at depth so depth need not be a power of two
    always_ff @(posedge i_sb_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous write and pop leaves count unchanged
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // first word fall through
    assign o_head  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));

endmodule

/* tx/sb_ser_ctrl.sv */
`include "sb_defs.svh"

module sb_ser_ctrl (
    input  logic            i_sb_clk,
    input  logic            i_reset,
    input  logic            i_empty,
    input  sb_pkg::sb_pkt_t i_head,
    output logic            o_pop,
    output logic            o_ser_en,
    output sb_pkg::sb_pkt_t o_ser_data
);

    localparam int MAX_CYC = (`SB_SER_CYCLES > `SB_GAP_CYCLES) ?
                             `SB_SER_CYCLES : `SB_GAP_CYCLES;
    localparam int CNT_W   = $clog2(MAX_CYC);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_GAP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;

    // pop the head as soon as idle and something is queued
    assign o_pop = (state == ST_IDLE) & ~i_empty;

    always_ff @(posedge i_sb_clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (o_pop) begin
                        state <= ST_SHIFT;
                    end
                end
                // serializer clock enabled for one packet
                ST_SHIFT: begin
                    if (cnt == CNT_W'(`SB_SER_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= ST_GAP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // idle gap between packets
                ST_GAP: begin
                    if (cnt == CNT_W'(`SB_GAP_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // packet held stable for the whole enable window
    always_ff @(posedge i_sb_clk) begin
        if (o_pop) begin
            o_ser_data <= i_head;
        end
    end

    assign o_ser_en = (state == ST_SHIFT);

endmodule

/* src/sb_rx_dispatch.sv */
`include "sb_defs.svh"

module sb_rx_dispatch (
    input  logic                    i_sb_clk,
    input  logic                    i_reset,
    input  sb_pkg::ltsm_state_t     i_state,
    input  logic                    i_deser_done,
    input  sb_pkg::sb_pkt_t         i_deser_data,
    output logic                    o_msg_valid_rdi,
    output logic [`SB_MSG_NO_W-1:0] o_msg_no_rdi,
    output logic                    o_mb_msg_valid,
    output logic [`SB_MSG_NO_W-1:0] o_mb_msg_no,
    output logic [`SB_INFO_W-1:0]   o_mb_msg_info,
    output logic [`SB_DATA_W-1:0]   o_mb_data,
    output logic                    o_parity_error
);

    logic [`SB_CODE_HI-`SB_CODE_LO:0] code;
    logic                             par_ok;
    logic                             is_rdi;
    logic                             in_training;
    logic                             to_rdi;
    logic                             to_mb;

    assign code   = i_deser_data[`SB_CODE_HI:`SB_CODE_LO];
    // even parity, xor of every bit is zero
    assign par_ok = ~^i_deser_data;
    assign is_rdi = (code == `SB_CODE_RDI_REQ) || (code == `SB_CODE_RDI_RSP);

    // states where the training fsm owns the sideband
    assign in_training = (i_state == sb_pkg::RESET)         ||
                         (i_state == sb_pkg::SBINIT)        ||
                         (i_state == sb_pkg::MBINIT)        ||
                         (i_state == sb_pkg::MBTRAIN)       ||
                         (i_state == sb_pkg::TRAINERROR_HS) ||
                         (i_state == sb_pkg::PHYRETRAIN);

    assign to_rdi = i_deser_done & par_ok & is_rdi;
    // non-rdi packets outside training are dropped
    assign to_mb  = i_deser_done & par_ok & ~is_rdi & in_training;

    // one-cycle pulses
    always_ff @(posedge i_sb_clk) begin
        if (i_reset) begin
            o_msg_valid_rdi <= 1'b0;
            o_mb_msg_valid  <= 1'b0;
            o_parity_error  <= 1'b0;
        end else begin
            o_msg_valid_rdi <= to_rdi;
            o_mb_msg_valid  <= to_mb;
            o_parity_error  <= i_deser_done & ~par_ok;
        end
    end

    // payload fields, loaded only on their own route
    always_ff @(posedge i_sb_clk) begin
        if (to_rdi) begin
            o_msg_no_rdi <= i_deser_data[`SB_SUB_LO +: `SB_MSG_NO_W];
        end
        if (to_mb) begin
            o_mb_msg_no   <= i_deser_data[`SB_SUB_LO +: `SB_MSG_NO_W];
            o_mb_msg_info <= i_deser_data[`SB_INFO_HI:`SB_INFO_LO];
            o_mb_data     <= i_deser_data[`SB_DATA_HI:`SB_DATA_LO];
        end
    end

endmodule

/* src/sb_top.sv */
`include "sb_defs.svh"

module sb_top (
    input  logic                    i_sb_clk,
    input  logic                    i_reset,
    // rdi message source
    input  logic                    i_msg_valid_rdi,
    input  logic [`SB_MSG_NO_W-1:0] i_msg_no_rdi,
    // mainband training message source
    input  logic                    i_msg_valid,
    input  logic [`SB_MSG_NO_W-1:0] i_msg_no,
    input  logic [`SB_INFO_W-1:0]   i_msg_info,
    input  logic [`SB_DATA_W-1:0]   i_data_bus,
    input  sb_pkg::ltsm_state_t     i_state,
    // deserializer side
    input  logic                    i_deser_done,
    input  sb_pkg::sb_pkt_t         i_deser_data,
    output logic                    o_msg_done_rdi,
    output logic                    o_busy,
    // serializer side
    output sb_pkg::sb_pkt_t         o_fifo_data,
    output logic                    o_ser_en,
    output logic                    o_mb_fifo_empty,
    // received messages
    output logic                    o_msg_valid_rdi,
    output logic [`SB_MSG_NO_W-1:0] o_msg_no_rdi,
    output logic                    o_mb_msg_valid,
    output logic [`SB_MSG_NO_W-1:0] o_mb_msg_no,
    output logic [`SB_INFO_W-1:0]   o_mb_msg_info,
    output logic [`SB_DATA_W-1:0]   o_mb_data,
    output logic                    o_parity_error
);

    // encoder to arbiter
    logic            rdi_req;
    logic            mb_req;
    logic            rdi_grant;
    logic            mb_grant;
    sb_pkg::sb_pkt_t rdi_pkt;
    sb_pkg::sb_pkt_t mb_pkt;

    // arbiter to fifo, fifo to serializer control
    logic            fifo_wr_en;
    sb_pkg::sb_pkt_t fifo_wr_data;
    sb_pkg::sb_pkt_t fifo_head;
    logic            fifo_empty;
    logic            fifo_full;
    logic            fifo_pop;

    assign o_mb_fifo_empty = fifo_empty;

    sb_rdi_tx_encoder u_rdi_enc (
        .i_sb_clk    (i_sb_clk),
        .i_reset     (i_reset),
        .i_msg_valid (i_msg_valid_rdi),
        .i_msg_no    (i_msg_no_rdi),
        .i_grant     (rdi_grant),
        .o_req       (rdi_req),
        .o_pkt       (rdi_pkt),
        .o_msg_done  (o_msg_done_rdi)
    );

    sb_mb_tx_encoder u_mb_enc (
        .i_sb_clk    (i_sb_clk),
        .i_reset     (i_reset),
        .i_msg_valid (i_msg_valid),
        .i_msg_no    (i_msg_no),
        .i_msg_info  (i_msg_info),
        .i_data_bus  (i_data_bus),
        .i_grant     (mb_grant),
        .o_req       (mb_req),
        .o_pkt       (mb_pkt),
        .o_busy      (o_busy)
    );

    // rdi wins when both sources are pending
    sb_tx_arbiter u_arb (
        .i_rdi_req   (rdi_req),
        .i_rdi_pkt   (rdi_pkt),
        .i_mb_req    (mb_req),
        .i_mb_pkt    (mb_pkt),
        .i_fifo_full (fifo_full),
        .o_rdi_grant (rdi_grant),
        .o_mb_grant  (mb_grant),
        .o_wr_en     (fifo_wr_en),
        .o_wr_data   (fifo_wr_data)
    );

    sb_tx_fifo #(
        .DEPTH (`SB_FIFO_DEPTH)
    ) u_tx_fifo (
        .i_sb_clk  (i_sb_clk),
        .i_reset   (i_reset),
        .i_wr_en   (fifo_wr_en),
        .i_wr_data (fifo_wr_data),
        .i_pop     (fifo_pop),
        .o_head    (fifo_head),
        .o_empty   (fifo_empty),
        .o_full    (fifo_full)
    );

    sb_ser_ctrl u_ser_ctrl (
        .i_sb_clk   (i_sb_clk),
        .i_reset    (i_reset),
        .i_empty    (fifo_empty),
        .i_head     (fifo_head),
        .o_pop      (fifo_pop),
        .o_ser_en   (o_ser_en),
        .o_ser_data (o_fifo_data)
    );

    sb_rx_dispatch u_rx_dispatch (
        .i_sb_clk        (i_sb_clk),
        .i_reset         (i_reset),
        .i_state         (i_state),
        .i_deser_done    (i_deser_done),
        .i_deser_data    (i_deser_data),
        .o_msg_valid_rdi (o_msg_valid_rdi),
        .o_msg_no_rdi    (o_msg_no_rdi),
        .o_mb_msg_valid  (o_mb_msg_valid),
        .o_mb_msg_no     (o_mb_msg_no),
        .o_mb_msg_info   (o_mb_msg_info),
        .o_mb_data       (o_mb_data),
        .o_parity_error  (o_parity_error)
    );

endmodule

/* tests/sb_tb_ref.svh */
`ifndef SB_TB_REF_SVH
`define SB_TB_REF_SVH

// rx routing outcomes
localparam int ROUTE_DROP = 0;
localparam int ROUTE_RDI  = 1;
localparam int ROUTE_MB   = 2;
localparam int ROUTE_PERR = 3;

// even parity, xor over all 64 bits is zero
function automatic bit parity_ok(input sb_pkg::sb_pkt_t pkt);
    return (^pkt) == 1'b0;
endfunction

// top bit chosen so the whole word has even parity
function automatic sb_pkg::sb_pkt_t add_parity(input sb_pkg::sb_pkt_t pkt);
    sb_pkg::sb_pkt_t p;
    p = pkt;
    p[`SB_PAR_BIT] = 1'b0;
    p[`SB_PAR_BIT] = ^p;
    return p;
endfunction

function automatic sb_pkg::sb_pkt_t build_rdi_pkt(input logic [`SB_MSG_NO_W-1:0] no);
    sb_pkg::sb_pkt_t p;
    p = '0;
    p[`SB_OP_HI:`SB_OP_LO] = `SB_OP_NODATA;
    p[`SB_CODE_HI:`SB_CODE_LO] = `SB_CODE_RDI_REQ;
    p[`SB_SUB_HI:`SB_SUB_LO] = {4'h0, no};
    return add_parity(p);
endfunction

function automatic sb_pkg::sb_pkt_t build_mb_pkt(input logic [`SB_MSG_NO_W-1:0] no,
                                                 input logic [`SB_INFO_W-1:0] info,
                                                 input logic [`SB_DATA_W-1:0] data);
    sb_pkg::sb_pkt_t p;
    p = '0;
    p[`SB_OP_HI:`SB_OP_LO] = `SB_OP_DATA;
    p[`SB_CODE_HI:`SB_CODE_LO] = `SB_CODE_MB;
    p[`SB_SUB_HI:`SB_SUB_LO] = {4'h0, no};
    p[`SB_INFO_HI:`SB_INFO_LO] = info;
    p[`SB_DATA_HI:`SB_DATA_LO] = data;
    return add_parity(p);
endfunction

// where a received packet should land for a given training state
function automatic int rx_route(input sb_pkg::sb_pkt_t pkt, input sb_pkg::ltsm_state_t st);
    logic [7:0] code;
    code = pkt[`SB_CODE_HI:`SB_CODE_LO];
    if (!parity_ok(pkt)) begin
        return ROUTE_PERR;
    end
    if (code == `SB_CODE_RDI_REQ || code == `SB_CODE_RDI_RSP) begin
        return ROUTE_RDI;
    end
    case (st)
        sb_pkg::RESET, sb_pkg::SBINIT, sb_pkg::MBINIT, sb_pkg::MBTRAIN,
        sb_pkg::TRAINERROR_HS, sb_pkg::PHYRETRAIN: return ROUTE_MB;
        default: return ROUTE_DROP;
    endcase
endfunction

`endif

/* tests/tb_sb_top.sv */
`include "sb_defs.svh"

module tb_sb_top;

    // 12 packets of about 100 cycles each, plus margin
    localparam int NUM_PKTS       = 12;
    localparam int CYCLES_PER_PKT = 100;
    localparam int MAX_CYCLES     = NUM_PKTS * CYCLES_PER_PKT + 400;

    logic                    clk;
    logic                    i_reset;
    logic                    i_msg_valid_rdi;
    logic [`SB_MSG_NO_W-1:0] i_msg_no_rdi;
    logic                    i_msg_valid;
    logic [`SB_MSG_NO_W-1:0] i_msg_no;
    logic [`SB_INFO_W-1:0]   i_msg_info;
    logic [`SB_DATA_W-1:0]   i_data_bus;
    sb_pkg::ltsm_state_t     i_state;
    logic                    i_deser_done;
    sb_pkg::sb_pkt_t         i_deser_data;
    logic                    o_msg_done_rdi;
    logic                    o_busy;
    sb_pkg::sb_pkt_t         o_fifo_data;
    logic                    o_ser_en;
    logic                    o_mb_fifo_empty;
    logic                    o_msg_valid_rdi;
    logic [`SB_MSG_NO_W-1:0] o_msg_no_rdi;
    logic                    o_mb_msg_valid;
    logic [`SB_MSG_NO_W-1:0] o_mb_msg_no;
    logic [`SB_INFO_W-1:0]   o_mb_msg_info;
    logic [`SB_DATA_W-1:0]   o_mb_data;
    logic                    o_parity_error;

    integer          seed;
    int              err_count = 0;
    int              check_count = 0;
    int              test_count = 0;
    int              cycle_count = 0;
    // expected packets in serializer order
    sb_pkg::sb_pkt_t exp_q[$];
    sb_pkg::sb_pkt_t start_data;
    logic            ser_en_q = 1'b0;
    logic            window_seen = 1'b0;
    logic            busy_seen = 1'b0;
    int              high_run = 0;
    int              low_run = 0;
    int              windows_done = 0;
    int              pkts_sent = 0;
    int              done_count = 0;
    int              rdi_sent = 0;
    int              busy_run = 0;
    int              max_busy_run = 0;

    `include "sb_tb_ref.svh"

    sb_top dut0 (
        .i_sb_clk        (clk),
        .i_reset         (i_reset),
        .i_msg_valid_rdi (i_msg_valid_rdi),
        .i_msg_no_rdi    (i_msg_no_rdi),
        .i_msg_valid     (i_msg_valid),
        .i_msg_no        (i_msg_no),
        .i_msg_info      (i_msg_info),
        .i_data_bus      (i_data_bus),
        .i_state         (i_state),
        .i_deser_done    (i_deser_done),
        .i_deser_data    (i_deser_data),
        .o_msg_done_rdi  (o_msg_done_rdi),
        .o_busy          (o_busy),
        .o_fifo_data     (o_fifo_data),
        .o_ser_en        (o_ser_en),
        .o_mb_fifo_empty (o_mb_fifo_empty),
        .o_msg_valid_rdi (o_msg_valid_rdi),
        .o_msg_no_rdi    (o_msg_no_rdi),
        .o_mb_msg_valid  (o_mb_msg_valid),
        .o_mb_msg_no     (o_mb_msg_no),
        .o_mb_msg_info   (o_mb_msg_info),
        .o_mb_data       (o_mb_data),
        .o_parity_error  (o_parity_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    task automatic end_test(input string name, input int errs0);
        test_count++;
        if (err_count == errs0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs0);
        end
    endtask

    // drive point, shortly after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // compare process, sampled on the falling edge
    always @(negedge clk) begin
        if (!i_reset) begin
            if (o_msg_done_rdi) begin
                done_count++;
            end
            if (o_busy) begin
                busy_seen = 1'b1;
                busy_run++;
                if (busy_run > max_busy_run) begin
                    max_busy_run = busy_run;
                end
            end else begin
                busy_run = 0;
            end
            if (o_ser_en && !ser_en_q) begin
                // start of a serializer window
                if (window_seen && low_run < `SB_GAP_CYCLES) begin
                    flag_error($sformatf("o_ser_en low only %0d cycles between packets", low_run));
                end
                if (exp_q.size() == 0) begin
                    flag_error("a packet was serialized while none was expected");
                end else begin
                    check("o_fifo_data", o_fifo_data, exp_q.pop_front());
                end
                start_data = o_fifo_data;
                high_run = 1;
            end else if (o_ser_en) begin
                high_run++;
                // payload must hold for the whole window
                if (o_fifo_data !== start_data) begin
                    check("o_fifo_data in window", o_fifo_data, start_data);
                end
            end else if (ser_en_q) begin
                check("o_ser_en window length", high_run, `SB_SER_CYCLES);
                windows_done++;
                window_seen = 1'b1;
                low_run = 1;
            end else begin
                low_run++;
            end
            ser_en_q = o_ser_en;
        end
    end

    // strobe the rdi source once its previous packet was written
    task automatic send_rdi(input logic [`SB_MSG_NO_W-1:0] no);
        step();
        while (done_count != rdi_sent) begin
            step();
        end
        i_msg_valid_rdi = 1'b1;
        i_msg_no_rdi    = no;
        step();
        i_msg_valid_rdi = 1'b0;
        rdi_sent++;
    endtask

    task automatic send_mb(input logic [`SB_MSG_NO_W-1:0] no, input logic [`SB_INFO_W-1:0] info,
                           input logic [`SB_DATA_W-1:0] data);
        step();
        while (o_busy) begin
            step();
        end
        i_msg_valid = 1'b1;
        i_msg_no    = no;
        i_msg_info  = info;
        i_data_bus  = data;
        step();
        i_msg_valid = 1'b0;
    endtask

    task automatic wait_windows(input int n);
        while (windows_done < n) begin
            step();
        end
    endtask

    function automatic sb_pkg::sb_pkt_t random_pkt(input logic [7:0] code);
        sb_pkg::sb_pkt_t p;
        p = {$random(seed), $random(seed)};
        p[`SB_CODE_HI:`SB_CODE_LO] = code;
        return add_parity(p);
    endfunction

    // one received packet, outputs one cycle after done
    task automatic rx_packet(input sb_pkg::sb_pkt_t pkt, input sb_pkg::ltsm_state_t st);
        int route;
        route = rx_route(pkt, st);
        step();
        i_deser_done = 1'b1;
        i_deser_data = pkt;
        i_state      = st;
        step();
        i_deser_done = 1'b0;
        check("o_msg_valid_rdi", o_msg_valid_rdi, route == ROUTE_RDI);
        check("o_mb_msg_valid", o_mb_msg_valid, route == ROUTE_MB);
        check("o_parity_error", o_parity_error, route == ROUTE_PERR);
        if (route == ROUTE_RDI) begin
            check("o_msg_no_rdi", o_msg_no_rdi, pkt[`SB_SUB_LO +: `SB_MSG_NO_W]);
        end
        if (route == ROUTE_MB) begin
            check("o_mb_msg_no", o_mb_msg_no, pkt[`SB_SUB_LO +: `SB_MSG_NO_W]);
            check("o_mb_msg_info", o_mb_msg_info, pkt[`SB_INFO_HI:`SB_INFO_LO]);
            check("o_mb_data", o_mb_data, pkt[`SB_DATA_HI:`SB_DATA_LO]);
        end
        step();
        // pulses are gone the cycle after
        check("o_msg_valid_rdi", o_msg_valid_rdi, 0);
        check("o_mb_msg_valid", o_mb_msg_valid, 0);
        check("o_parity_error", o_parity_error, 0);
    endtask

    task automatic reset_values();
        int errs0;
        errs0 = err_count;
        check("o_ser_en", o_ser_en, 0);
        check("o_msg_done_rdi", o_msg_done_rdi, 0);
        check("o_busy", o_busy, 0);
        check("o_mb_fifo_empty", o_mb_fifo_empty, 1);
        check("o_msg_valid_rdi", o_msg_valid_rdi, 0);
        check("o_mb_msg_valid", o_mb_msg_valid, 0);
        check("o_parity_error", o_parity_error, 0);
        end_test("reset values", errs0);
    endtask

    task automatic rdi_single();
        logic [`SB_MSG_NO_W-1:0] no;
        int                      errs0;
        int                      done0;
        errs0 = err_count;
        done0 = done_count;
        no = $random(seed);
        exp_q.push_back(build_rdi_pkt(no));
        send_rdi(no);
        pkts_sent++;
        wait_windows(pkts_sent);
        check("o_msg_done_rdi pulses", done_count - done0, 1);
        end_test("rdi single", errs0);
    endtask

    task automatic mb_single();
        logic [`SB_MSG_NO_W-1:0] no;
        logic [`SB_INFO_W-1:0]   info;
        logic [`SB_DATA_W-1:0]   data;
        int                      errs0;
        errs0 = err_count;
        busy_seen = 1'b0;
        no   = $random(seed);
        info = $random(seed);
        data = $random(seed);
        exp_q.push_back(build_mb_pkt(no, info, data));
        send_mb(no, info, data);
        pkts_sent++;
        wait_windows(pkts_sent);
        check("o_busy seen high", busy_seen, 1);
        check("o_busy", o_busy, 0);
        end_test("mb single", errs0);
    endtask

    task automatic same_cycle_pair();
        logic [`SB_MSG_NO_W-1:0] rno;
        logic [`SB_MSG_NO_W-1:0] mno;
        logic [`SB_INFO_W-1:0]   info;
        logic [`SB_DATA_W-1:0]   data;
        int                      errs0;
        int                      done0;
        errs0 = err_count;
        done0 = done_count;
        rno  = $random(seed);
        mno  = $random(seed);
        info = $random(seed);
        data = $random(seed);
        // rdi has priority for the fifo write
        exp_q.push_back(build_rdi_pkt(rno));
        exp_q.push_back(build_mb_pkt(mno, info, data));
        step();
        while (o_busy || done_count != rdi_sent) begin
            step();
        end
        i_msg_valid_rdi = 1'b1;
        i_msg_no_rdi    = rno;
        i_msg_valid     = 1'b1;
        i_msg_no        = mno;
        i_msg_info      = info;
        i_data_bus      = data;
        step();
        i_msg_valid_rdi = 1'b0;
        i_msg_valid     = 1'b0;
        rdi_sent++;
        pkts_sent += 2;
        wait_windows(pkts_sent);
        check("o_msg_done_rdi pulses", done_count - done0, 1);
        end_test("same cycle pair", errs0);
    endtask

    task automatic alternating_burst();
        logic [`SB_MSG_NO_W-1:0] no [8];
        logic [`SB_INFO_W-1:0]   info [8];
        logic [`SB_DATA_W-1:0]   data [8];
        sb_pkg::sb_pkt_t         pkts [8];
        int                      errs0;
        int                      done0;
        errs0 = err_count;
        done0 = done_count;
        max_busy_run = 0;
        // even slots rdi, odd slots mb
        for (int i = 0; i < 8; i++) begin
            no[i]   = $random(seed);
            info[i] = $random(seed);
            data[i] = $random(seed);
            pkts[i] = (i % 2 == 0) ? build_rdi_pkt(no[i]) : build_mb_pkt(no[i], info[i], data[i]);
        end
        // one packet in the serializer and four in the fifo go in strobe order
        for (int i = 0; i < 5; i++) begin
            exp_q.push_back(pkts[i]);
        end
        // mb 5 and rdi 6 both wait on the full fifo, rdi takes the freed slot
        exp_q.push_back(pkts[6]);
        exp_q.push_back(pkts[5]);
        exp_q.push_back(pkts[7]);
        // serializer idle before the burst starts
        while (low_run <= `SB_GAP_CYCLES) begin
            step();
        end
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                send_rdi(no[i]);
            end else begin
                send_mb(no[i], info[i], data[i]);
            end
        end
        pkts_sent += 8;
        wait_windows(pkts_sent);
        check("o_msg_done_rdi pulses", done_count - done0, 4);
        if (max_busy_run < `SB_SER_CYCLES) begin
            flag_error("o_busy was not held while the fifo was full");
        end
        check("o_mb_fifo_empty", o_mb_fifo_empty, 1);
        end_test("alternating burst", errs0);
    endtask

    task automatic rx_routing();
        sb_pkg::sb_pkt_t pkt;
        int              errs0;
        errs0 = err_count;
        for (int k = 0; k < 4; k++) begin
            pkt = random_pkt((k % 2 == 0) ? `SB_CODE_RDI_REQ : `SB_CODE_RDI_RSP);
            rx_packet(pkt, sb_pkg::ltsm_state_t'({$random(seed)} % 13));
        end
        rx_packet(random_pkt(`SB_CODE_MB), sb_pkg::MBTRAIN);
        rx_packet(random_pkt(`SB_CODE_MB), sb_pkg::SBINIT);
        // dropped outside training
        rx_packet(random_pkt(`SB_CODE_MB), sb_pkg::ACTIVE);
        pkt = random_pkt(`SB_CODE_MB);
        pkt[`SB_PAR_BIT] = ~pkt[`SB_PAR_BIT];
        rx_packet(pkt, sb_pkg::MBTRAIN);
        end_test("rx routing", errs0);
    endtask

    initial begin
        seed            = 63483;
        i_reset         = 1'b1;
        i_msg_valid_rdi = 1'b0;
        i_msg_no_rdi    = '0;
        i_msg_valid     = 1'b0;
        i_msg_no        = '0;
        i_msg_info      = '0;
        i_data_bus      = '0;
        i_state         = sb_pkg::RESET;
        i_deser_done    = 1'b0;
        i_deser_data    = '0;
        repeat (3) @(posedge clk);
        #1;
        i_reset = 1'b0;
        reset_values();
        rdi_single();
        mb_single();
        same_cycle_pair();
        alternating_burst();
        rx_routing();
        if (exp_q.size() != 0) begin
            flag_error($sformatf("%0d expected packets never serialized", exp_q.size()));
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
+incdir+tests
common/sb_pkg.sv
tx/sb_rdi_tx_encoder.sv
tx/sb_mb_tx_encoder.sv
tx/sb_tx_arbiter.sv
tx/sb_tx_fifo.sv
tx/sb_ser_ctrl.sv
src/sb_rx_dispatch.sv
src/sb_top.sv
tests/tb_sb_top.sv

/* Bender.yml */
package:
  name: sb_link

sources:
  - include_dirs:
      - common
    files:
      - common/sb_pkg.sv
      - tx/sb_rdi_tx_encoder.sv
      - tx/sb_mb_tx_encoder.sv
      - tx/sb_tx_arbiter.sv
      - tx/sb_tx_fifo.sv
      - tx/sb_ser_ctrl.sv
      - src/sb_rx_dispatch.sv
      - src/sb_top.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/tb_sb_top.sv
